// File: src/nn_pkg.sv
`default_nettype none

package nn_pkg;

	//////////////////// Network dimensions

	// Neurons per layer, also values per vector
	localparam int NUM_NEURONS = 6;
	// Activation and weight widths
	localparam int DATA_W      = 9;
	localparam int WEIGHT_W    = 17;
	// Fixed point scaling of each sum
	localparam int FRAC_SHIFT  = 8;

	localparam int VEC_W  = NUM_NEURONS * DATA_W;
	localparam int WSET_W = NUM_NEURONS * NUM_NEURONS * WEIGHT_W;

	//////////////////// Data types

	typedef logic signed [DATA_W-1:0]   data_t;
	typedef logic        [VEC_W-1:0]    vec_t;
	typedef logic signed [WEIGHT_W-1:0] weight_t;
	// Neuron n, input i at slot n*6+i
	typedef logic        [WSET_W-1:0]   weight_set_t;
	// Enough for four layers
	typedef logic        [1:0]          layer_t;

	// Aggregator sequencing
	typedef enum logic [1:0] {
		IDLE,
		LAUNCH,
		WAIT_LAYER,
		DONE
	} agg_state_t;

	// Aggregator to neuron array, 667 bits
	typedef struct packed {
		logic        start;
		vec_t        inputs;
		weight_set_t weights;
	} layer_req_t;

	// Neuron array back to aggregator
	typedef struct packed {
		logic valid;
		vec_t outputs;
	} layer_rsp_t;

endpackage

`default_nettype wire

// File: src/weight_rom.sv
`default_nettype none

module weight_rom import nn_pkg::*; #(
	parameter int NUM_LAYERS = 4
) (
	input  layer_t      layer_num,
	output weight_set_t out_weights
);

	localparam int ROW_W = NUM_NEURONS * WEIGHT_W;

	// Packs one neuron's six weights, input 0 in the low bits
	function automatic logic [ROW_W-1:0] wrow(
		input int w0,
		input int w1,
		input int w2,
		input int w3,
		input int w4,
		input int w5
	);
		return {weight_t'(w5), weight_t'(w4), weight_t'(w3),
			weight_t'(w2), weight_t'(w1), weight_t'(w0)};
	endfunction

	//////////////////// Weight table

	// Scale is 256 per unit after the shift
	always_comb begin
		out_weights = '0;
		if (int'(layer_num) < NUM_LAYERS) begin
			case (layer_num)
				2'd0: begin
					out_weights[0*ROW_W +: ROW_W] = wrow( 300, -120,   64,   90,  -40,  150);
					out_weights[1*ROW_W +: ROW_W] = wrow(-200,  256,  -80,   30,  110,  -60);
					out_weights[2*ROW_W +: ROW_W] = wrow( 128,  128, -256,   70,   20,   45);
					out_weights[3*ROW_W +: ROW_W] = wrow( -90,  -30,  140, -180,  256,   60);
					out_weights[4*ROW_W +: ROW_W] = wrow( 220,   75,   35, -150,  -95,  180);
					out_weights[5*ROW_W +: ROW_W] = wrow( -60,  190,  100,   85, -210,  128);
				end
				2'd1: begin
					out_weights[0*ROW_W +: ROW_W] = wrow( 180,  -70,  120,   40,  -30,   95);
					out_weights[1*ROW_W +: ROW_W] = wrow( -45,  210,  -60,  150,   80, -120);
					out_weights[2*ROW_W +: ROW_W] = wrow( 256,  -40,   30,  -90,  140,   60);
					out_weights[3*ROW_W +: ROW_W] = wrow(  70,   90, -200,  160,  -50,  110);
					out_weights[4*ROW_W +: ROW_W] = wrow(-130,   55,  175,   20,  230,  -85);
					out_weights[5*ROW_W +: ROW_W] = wrow(  95, -160,   65,  200,  -25,  145);
				end
				2'd2: begin
					out_weights[0*ROW_W +: ROW_W] = wrow( 240,   60,  -90,  130,   50,  -70);
					out_weights[1*ROW_W +: ROW_W] = wrow( -80,  170,  110,  -40,  190,   30);
					out_weights[2*ROW_W +: ROW_W] = wrow( 100, -150,  220,   60,  -20,  140);
					out_weights[3*ROW_W +: ROW_W] = wrow(  35,  125,  -55,  256,   85, -100);
					out_weights[4*ROW_W +: ROW_W] = wrow( 160,  -95,   45,  -70,  200,  115);
					out_weights[5*ROW_W +: ROW_W] = wrow( -30,   80,  150,   90, -140,  210);
				end
				// Large weights, pushes outputs into saturation
				2'd3: begin
					out_weights[0*ROW_W +: ROW_W] = wrow( 2048,  1500,  -300,  1800,   900,  1200);
					out_weights[1*ROW_W +: ROW_W] = wrow(-2500, -1800, -3000,  -900, -1200, -2200);
					out_weights[2*ROW_W +: ROW_W] = wrow( 1600, -1400,  2200,   700,  -800,  1300);
					out_weights[3*ROW_W +: ROW_W] = wrow( 3000,  2600,  1900,  2400,  2100,  2800);
					out_weights[4*ROW_W +: ROW_W] = wrow( -700,  1100, -1600,  2500,   600,  -900);
					out_weights[5*ROW_W +: ROW_W] = wrow(  900, -2100,  1400,  -500,  3200, -1000);
				end
				default: out_weights = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/neuron_layer.sv
`default_nettype none

module neuron_layer import nn_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  layer_req_t req,
	output layer_rsp_t rsp
);

	localparam int ACC_W   = 32;
	localparam int IDX_W   = $clog2(NUM_NEURONS + 1);
	localparam int SAT_MAX = 2 ** (DATA_W - 1) - 1;
	localparam int SAT_MIN = -(2 ** (DATA_W - 1));

	logic signed [ACC_W-1:0] acc  [NUM_NEURONS];
	logic signed [ACC_W-1:0] prod [NUM_NEURONS];
	logic [IDX_W-1:0] idx;
	logic [IDX_W-1:0] mac_idx;
	logic             running;
	logic             mac_phase;
	logic             fin_phase;
	data_t            mac_in;
	vec_t             out_vec;
	vec_t             out_q;
	logic             valid_q;

	// Shift, clamp to 9 bits, then ReLU
	function automatic data_t squash(input logic signed [ACC_W-1:0] sum);
		logic signed [ACC_W-1:0] shifted;
		data_t sat;
		shifted = sum >>> FRAC_SHIFT;
		if (shifted > SAT_MAX)
			sat = data_t'(SAT_MAX);
		else if (shifted < SAT_MIN)
			sat = data_t'(SAT_MIN);
		else
			sat = data_t'(shifted);
		if (sat < 0)
			sat = '0;
		return sat;
	endfunction

	assign mac_phase = running && (idx < NUM_NEURONS);
	assign fin_phase = running && (idx == NUM_NEURONS);

	//////////////////// Multiply stage

	// Input 0 on the start cycle, then walk the counter
	always_comb begin
		if (req.start || !mac_phase)
			mac_idx = '0;
		else
			mac_idx = idx;
		mac_in = data_t'(req.inputs[mac_idx*DATA_W +: DATA_W]);
		for (int n = 0; n < NUM_NEURONS; n++) begin
			// Signed product, widened to the accumulator
			prod[n] = weight_t'(req.weights[(n*NUM_NEURONS + mac_idx)*WEIGHT_W +: WEIGHT_W])
				* mac_in;
		end
	end

	// Activation of every accumulator
	always_comb begin
		for (int n = 0; n < NUM_NEURONS; n++)
			out_vec[n*DATA_W +: DATA_W] = squash(acc[n]);
	end

	//////////////////// Control

	// Six MAC cycles, one finish cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			running <= 1'b0;
			idx     <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			if (req.start) begin
				running <= 1'b1;
				idx     <= IDX_W'(1);
			end else if (mac_phase) begin
				idx <= idx + 1'b1;
			end else if (fin_phase) begin
				running <= 1'b0;
				valid_q <= 1'b1;
			end
		end
	end

	// Accumulators and output vector
	always_ff @(posedge clk) begin
		for (int n = 0; n < NUM_NEURONS; n++) begin
			if (req.start)
				acc[n] <= prod[n];
			else if (mac_phase)
				acc[n] <= acc[n] + prod[n];
		end
		// Held until the next layer finishes
		if (fin_phase)
			out_q <= out_vec;
	end

	assign rsp = '{valid: valid_q, outputs: out_q};

endmodule

`default_nettype wire

// File: src/input_aggregator.sv
`default_nettype none

module input_aggregator import nn_pkg::*; #(
	parameter int NUM_LAYERS = 4
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  vec_t        start_input,
	output layer_t      layer_num,
	input  weight_set_t out_weights,
	output layer_req_t  req,
	input  layer_rsp_t  rsp,
	output vec_t        result,
	output logic        result_valid,
	output logic        busy
);

	agg_state_t state;
	vec_t       start_vec;
	vec_t       layer_vec;
	logic       last_layer;

	assign last_layer = (layer_num == layer_t'(NUM_LAYERS - 1));

	//////////////////// Layer sequencing

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= IDLE;
			layer_num <= '0;
			result    <= '0;
		end else begin
			case (state)
				// Only an external start leaves idle
				IDLE: begin
					if (start) begin
						state     <= LAUNCH;
						layer_num <= '0;
					end
				end
				// One cycle of req.start
				LAUNCH: state <= WAIT_LAYER;
				WAIT_LAYER: begin
					if (rsp.valid) begin
						if (last_layer) begin
							result <= rsp.outputs;
							state  <= DONE;
						end else begin
							layer_num <= layer_num + 1'b1;
							state     <= LAUNCH;
						end
					end
				end
				// Result pulse, then back to idle
				DONE: begin
					state     <= IDLE;
					layer_num <= '0;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Captured input and fed back layer output
	always_ff @(posedge clk) begin
		if (state == IDLE && start)
			start_vec <= start_input;
		if (state == WAIT_LAYER && rsp.valid)
			layer_vec <= rsp.outputs;
	end

	//////////////////// Request to neuron array

	// Stable from the launch until the response
	always_comb begin
		req.start   = (state == LAUNCH);
		req.inputs  = (layer_num == '0) ? start_vec : layer_vec;
		req.weights = out_weights;
	end

	assign result_valid = (state == DONE);
	// Stays up through the result cycle
	assign busy         = (state != IDLE);

endmodule

`default_nettype wire

// File: src/layer_multiplex_nn.sv
`default_nettype none

module layer_multiplex_nn import nn_pkg::*; #(
	parameter int NUM_LAYERS = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  vec_t start_input,
	output vec_t result,
	output logic result_valid,
	output logic busy
);

	layer_t      layer_num;
	weight_set_t weights;
	layer_req_t  req;
	layer_rsp_t  rsp;

	// Sequencer, one layer in flight
	input_aggregator #(
		.NUM_LAYERS(NUM_LAYERS)
	) u_aggregator (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.start_input (start_input),
		.layer_num   (layer_num),
		.out_weights (weights),
		.req         (req),
		.rsp         (rsp),
		.result      (result),
		.result_valid(result_valid),
		.busy        (busy)
	);

	// Weight set for the current layer
	weight_rom #(
		.NUM_LAYERS(NUM_LAYERS)
	) u_weight_rom (
		.layer_num  (layer_num),
		.out_weights(weights)
	);

	// Shared neuron array
	neuron_layer u_neuron_layer (
		.clk  (clk),
		.rst_n(rst_n),
		.req  (req),
		.rsp  (rsp)
	);

endmodule

`default_nettype wire

// File: sim/layer_multiplex_nn_assert.sv
`default_nettype none

module layer_multiplex_nn_assert import nn_pkg::*; #(
	parameter int NUM_LAYERS = 4
) (
	input logic   clk,
	input logic   rst_n,
	input logic   req_start,
	input logic   rsp_valid,
	input layer_t layer_num,
	input logic   result_valid
);

	// Set by a launch, cleared by its response
	logic in_flight;

	always_ff @(posedge clk) begin
		if (!rst_n)
			in_flight <= 1'b0;
		else if (req_start)
			in_flight <= 1'b1;
		else if (rsp_valid)
			in_flight <= 1'b0;
	end

	//////////////////// Handshake

	a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
		req_start |-> !in_flight) else $error("layer launched before previous response");
	a_rsp_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		req_start |-> ##7 rsp_valid) else $error("rsp.valid missing 7 cycles after req.start");
	a_rsp_has_req: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid |-> $past(req_start, 7)) else $error("rsp.valid without req.start 7 cycles earlier");
	// Last layer's response ends the run instead of stepping the index on
	a_layer_range: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && int'(layer_num) == NUM_LAYERS - 1 |=> result_valid)
		else $error("layer_num stepped past the last layer");
	a_result_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |=> !result_valid) else $error("result_valid longer than one cycle");

endmodule

`default_nettype wire

// File: sim/tb_layer_multiplex_nn.sv
`default_nettype none

module tb_layer_multiplex_nn import nn_pkg::*; ();

	localparam int NUM_LAYERS     = 4;
	localparam int CLK_PERIOD     = 20;
	localparam int RESET_CYCLES   = 16;
	localparam int MAX_VEC        = 32;
	// gap, six inputs, six expected outputs, dup flag
	localparam int WORDS_PER_VEC  = 14;
	localparam int RESULT_LATENCY = 33;
	localparam int DUP_START_AT   = 10;
	localparam int CYCLES_PER_VEC = 40;
	localparam int TIMEOUT_MARGIN = 100;

	logic clk;
	logic rst_n;
	logic start;
	vec_t start_input;
	vec_t result;
	logic result_valid;
	logic busy;

	logic [15:0] stim_mem [MAX_VEC*WORDS_PER_VEC];
	int num_vec;
	int cycle_cnt;
	int cycle_limit;
	bit finished;
	bit fail_shown;

	layer_multiplex_nn #(
		.NUM_LAYERS(NUM_LAYERS)
	) uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.start_input (start_input),
		.result      (result),
		.result_valid(result_valid),
		.busy        (busy)
	);

	// Protocol checks on the internal handshake
	bind layer_multiplex_nn layer_multiplex_nn_assert #(
		.NUM_LAYERS(NUM_LAYERS)
	) u_assert (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_start   (req.start),
		.rsp_valid   (rsp.valid),
		.layer_num   (layer_num),
		.result_valid(result_valid)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////// Timeout

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("Timeout: run still going after %0d cycles", cycle_cnt);
			$display("Regression failed");
			fail_shown = 1'b1;
			$fatal(1);
		end
	end

	// Run stopped early by a bound assertion
	final begin
		if (!finished && !fail_shown)
			$display("Regression failed");
	end

	//////////////////// Helpers

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("ERR @%0t %s expected %0h got %0h", $time, name, expected, actual);
		$display("Regression failed");
		fail_shown = 1'b1;
	endtask

	// Six stim words, element i in bits 9i and up
	function automatic vec_t field_vec(input int base);
		vec_t v;
		for (int i = 0; i < NUM_NEURONS; i++)
			v[i*DATA_W +: DATA_W] = stim_mem[base + i][DATA_W-1:0];
		return v;
	endfunction

	function automatic vec_t random_vec();
		vec_t v;
		for (int i = 0; i < NUM_NEURONS; i++)
			v[i*DATA_W +: DATA_W] = DATA_W'($urandom);
		return v;
	endfunction

	task automatic check_idle();
		assert (busy === 1'b0) else begin
			report_mismatch("busy", 64'(0), 64'(busy));
			$fatal(1);
		end
		assert (result_valid === 1'b0) else begin
			report_mismatch("result_valid", 64'(0), 64'(result_valid));
			$fatal(1);
		end
	endtask

	// Gap, start pulse, wait for the result and compare
	task automatic run_vector(input int v);
		int   base;
		int   gap;
		int   cyc;
		bit   dup;
		vec_t in_vec;
		vec_t exp_vec;
		base    = v * WORDS_PER_VEC;
		gap     = int'(stim_mem[base]);
		dup     = stim_mem[base + 13][0];
		in_vec  = field_vec(base + 1);
		exp_vec = field_vec(base + 7);
		// Junk on the data input while idle
		repeat (gap) begin
			@(negedge clk);
			check_idle();
			start_input = random_vec();
		end
		@(negedge clk);
		check_idle();
		start       = 1'b1;
		start_input = in_vec;
		cyc         = 0;
		do begin
			@(negedge clk);
			cyc++;
			start = 1'b0;
			// Live input is junk once the start vector is captured
			start_input = random_vec();
			// Start while busy, must be dropped
			if (dup && cyc == DUP_START_AT)
				start = 1'b1;
			assert (busy === 1'b1) else begin
				report_mismatch("busy", 64'(1), 64'(busy));
				$fatal(1);
			end
		end while (result_valid !== 1'b1);
		assert (cyc == RESULT_LATENCY) else begin
			report_mismatch("result_valid latency", 64'(RESULT_LATENCY), 64'(cyc));
			$fatal(1);
		end
		assert (result === exp_vec) else begin
			report_mismatch("result", 64'(exp_vec), 64'(result));
			$fatal(1);
		end
	endtask

	//////////////////// Main sequence

	initial begin
		start       = 1'b0;
		start_input = '0;
		rst_n       = 1'b0;
		cycle_cnt   = 0;
		cycle_limit = 0;
		finished    = 1'b0;
		fail_shown  = 1'b0;
		void'($urandom(32'h39317f32));
		for (int k = 0; k < $size(stim_mem); k++)
			stim_mem[k] = '1;
		$readmemh("sim/nn_stim.txt", stim_mem);
		// All-ones gap word marks the end of the table
		num_vec = 0;
		while (num_vec < MAX_VEC && stim_mem[num_vec*WORDS_PER_VEC] != 16'hffff)
			num_vec++;
		assert (num_vec > 0) else begin
			$display("No stimulus vectors could be read from sim/nn_stim.txt");
			$display("Regression failed");
			fail_shown = 1'b1;
			$fatal(1);
		end
		cycle_limit = TIMEOUT_MARGIN;
		for (int v = 0; v < num_vec; v++)
			cycle_limit += int'(stim_mem[v*WORDS_PER_VEC]) + CYCLES_PER_VEC;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_idle();
		assert (result === '0) else begin
			report_mismatch("result", 64'(0), 64'(result));
			$fatal(1);
		end
		for (int v = 0; v < num_vec; v++)
			run_vector(v);
		// No second pulse, no late result
		repeat (4) begin
			@(negedge clk);
			check_idle();
		end
		finished = 1'b1;
		if (!fail_shown)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/nn_stim.txt
// gap in0 in1 in2 in3 in4 in5 exp0 exp1 exp2 exp3 exp4 exp5 dup (hex words)
// Values are 9-bit two's complement, dup=1 sends a second start 10 cycles into the run
003 064 000 000 000 000 000 0ff 000 0ff 0ff 000 0ff 0
000 19c 000 000 000 000 000 0ff 000 0ff 0ff 0ff 000 0
000 002 000 000 000 000 000 002 000 016 019 000 007 1
005 1ce 1ce 1ce 1ce 1ce 1ce 000 000 000 000 000 000 0
000 0ff 000 000 000 000 000 0ff 000 0ff 0ff 000 0ff 1
002 100 000 000 000 000 000 0ff 000 0ff 0ff 0ff 000 0
000 000 000 000 000 000 000 000 000 000 000 000 000 0
001 1ff 000 000 000 000 000 000 000 000 000 000 000 0

// File: filelist.f
src/nn_pkg.sv
src/weight_rom.sv
src/neuron_layer.sv
src/input_aggregator.sv
src/layer_multiplex_nn.sv
sim/layer_multiplex_nn_assert.sv
sim/tb_layer_multiplex_nn.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_layer_multiplex_nn \
	-f filelist.f -o tb_sim

sim_out=$(./obj_dir/tb_sim 2>&1 || true)
echo "$sim_out"

if grep -q "Regression passed" <<< "$sim_out"; then
	exit 0
fi
exit 1
